// File: include/rv_ex_config.svh
`ifndef RV_EX_CONFIG_SVH
`define RV_EX_CONFIG_SVH

// Data path width of the integer core
`define XLEN        32

// Full PC width, bit 0 is carried even though it stays zero
`define PC_BITS     32

`define RESET_PC    32'h0000_0000

`define TB_LEN      40   // Default number of bench items

`endif

// File: design/rv_ex_pkg.sv
`include "rv_ex_config.svh"

package rv_ex_pkg;

    typedef logic [`XLEN-1:0]    xlen_t;
    typedef logic [`PC_BITS-1:0] pc_t;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_t;

    // Encoded exactly as funct3 of the branch instructions
    typedef enum logic [2:0] {
        BR_EQ = 3'b000, BR_NE = 3'b001, BR_LT = 3'b100,
        BR_GE = 3'b101, BR_LTU = 3'b110, BR_GEU = 3'b111
    } br_cond_t;

    typedef enum logic [1:0] {OP2_REG, OP2_IMM_I, OP2_FOUR} op2_src_t;

    typedef struct packed {
        alu_op_t  alu_op;
        logic     op1_pc;      // Operand 1 is the PC instead of rs1
        op2_src_t op2_src;
        br_cond_t br_cond;
        logic     is_branch;
        logic     is_jal;
        logic     is_jalr;
        logic     reg_write;
    } ex_ctrl_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } inst_b_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_j_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_b_t b;
        inst_j_t j;
    } inst_u;

endpackage

// File: design/rv_decode.sv
`timescale 1ns/1ps

module rv_decode
(
    input  rv_ex_pkg::inst_u    i_instr,
    output rv_ex_pkg::ex_ctrl_t o_ctrl,
    output logic [4:0]          o_rd,
    output rv_ex_pkg::xlen_t    o_imm_i,
    output rv_ex_pkg::xlen_t    o_imm_b,
    output rv_ex_pkg::xlen_t    o_imm_j
);

    import rv_ex_pkg::*;

    localparam int XW = $bits(xlen_t);

    ex_ctrl_t   ctrl;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;    // funct7[5], selects sub and sra

    // Shared ALU mapping of OP and OP-IMM, sub only exists in the register form
    function automatic alu_op_t alu_decode
    (
        input logic [2:0] f3,
        input logic       f7_alt,
        input logic       is_reg
    );
        alu_op_t op;
        case (f3)
            3'b000:  op = (f7_alt && is_reg) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = f7_alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = i_instr.r.opcode;
    assign funct3 = i_instr.r.funct3;
    assign alt    = i_instr.r.funct7[5];

    always_comb
    begin
        ctrl         = '0;
        ctrl.alu_op  = ALU_ADD;
        ctrl.op2_src = OP2_REG;
        ctrl.br_cond = BR_EQ;
        case (opcode)
            OPC_OP:
            begin
                ctrl.alu_op    = alu_decode(funct3, alt, 1'b1);
                ctrl.reg_write = 1'b1;
            end
            OPC_OP_IMM:
            begin
                ctrl.alu_op    = alu_decode(funct3, alt, 1'b0);
                ctrl.op2_src   = OP2_IMM_I;
                ctrl.reg_write = 1'b1;
            end
            OPC_JAL, OPC_JALR:
            begin
                ctrl.op1_pc    = 1'b1;     // Link value is PC + 4 through the adder
                ctrl.op2_src   = OP2_FOUR;
                ctrl.is_jal    = (opcode == OPC_JAL);
                ctrl.is_jalr   = (opcode == OPC_JALR);
                ctrl.reg_write = 1'b1;
            end
            OPC_BRANCH:
            begin
                // funct3 values 010 and 011 are reserved and stay a bubble
                if (funct3[2:1] != 2'b01)
                begin
                    ctrl.is_branch = 1'b1;
                    ctrl.br_cond   = br_cond_t'(funct3);
                end
            end
            default: ;
        endcase
    end

    assign o_ctrl = ctrl;
    assign o_rd   = ctrl.reg_write ? i_instr.r.rd : 5'd0;

    //############################################################
    // Immediates, each read through its own view of the word
    //############################################################
    assign o_imm_i = {{(XW-12){i_instr.i.imm[11]}}, i_instr.i.imm};
    assign o_imm_b = {{(XW-12){i_instr.b.imm_12}}, i_instr.b.imm_11,
                      i_instr.b.imm_10_5, i_instr.b.imm_4_1, 1'b0};
    assign o_imm_j = {{(XW-20){i_instr.j.imm_20}}, i_instr.j.imm_19_12,
                      i_instr.j.imm_11, i_instr.j.imm_10_1, 1'b0};

endmodule

// File: design/rv_ex_operands.sv
`timescale 1ns/1ps

module rv_ex_operands
(
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_flush,
    input  logic                i_valid,
    output logic                o_ready,
    input  rv_ex_pkg::ex_ctrl_t i_ctrl,
    input  logic [4:0]          i_rd,
    input  rv_ex_pkg::xlen_t    i_imm_i,
    input  rv_ex_pkg::xlen_t    i_imm_b,
    input  rv_ex_pkg::xlen_t    i_imm_j,
    input  rv_ex_pkg::pc_t      i_pc,
    input  rv_ex_pkg::xlen_t    i_rs1_data,
    input  rv_ex_pkg::xlen_t    i_rs2_data,
    output logic                o_valid,
    input  logic                i_ready,
    output rv_ex_pkg::xlen_t    o_op1,
    output rv_ex_pkg::xlen_t    o_op2,
    output rv_ex_pkg::xlen_t    o_rs1_data,
    output rv_ex_pkg::xlen_t    o_rs2_data,
    output rv_ex_pkg::ex_ctrl_t o_ctrl,
    output logic [4:0]          o_rd,
    output rv_ex_pkg::pc_t      o_pc,
    output rv_ex_pkg::pc_t      o_target
);

    import rv_ex_pkg::*;

    logic     valid;
    ex_ctrl_t ctrl;
    logic [4:0] rd;
    xlen_t    imm_i, imm_b, imm_j;
    xlen_t    rs1_data, rs2_data;
    pc_t      pc;
    logic     accept;

    assign o_ready = !valid || i_ready;
    assign accept  = i_valid && o_ready;

    always_ff @(posedge i_clk)
    begin
        if (i_rst || i_flush)
        begin
            valid <= 1'b0;
            ctrl  <= '0;
        end
        else if (o_ready)
        begin
            valid <= i_valid;
            if (i_valid)
                ctrl <= i_ctrl;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (accept)
        begin
            rd       <= i_rd;
            imm_i    <= i_imm_i;
            imm_b    <= i_imm_b;
            imm_j    <= i_imm_j;
            pc       <= i_pc;
            rs1_data <= i_rs1_data;
            rs2_data <= i_rs2_data;
        end
    end

    //############################################################
    // Operand select and target adder
    //############################################################
    assign o_op1 = ctrl.op1_pc ? xlen_t'(pc) : rs1_data;

    always_comb
    begin
        case (ctrl.op2_src)
            OP2_IMM_I: o_op2 = imm_i;
            OP2_FOUR:  o_op2 = xlen_t'(4);
            default:   o_op2 = rs2_data;
        endcase
    end

    pc_t tgt_base, tgt_offset, tgt_sum;

    assign tgt_base   = ctrl.is_jalr ? pc_t'(rs1_data) : pc;
    assign tgt_offset = ctrl.is_jalr ? pc_t'(imm_i) :
                        ctrl.is_jal  ? pc_t'(imm_j) :
                                       pc_t'(imm_b);
    assign tgt_sum    = tgt_base + tgt_offset;
    assign o_target   = {tgt_sum[$bits(pc_t)-1:1], 1'b0};  // JALR drops bit 0

    assign o_valid    = valid;
    assign o_rs1_data = rs1_data;
    assign o_rs2_data = rs2_data;
    assign o_ctrl     = ctrl;
    assign o_rd       = rd;
    assign o_pc       = pc;

endmodule

// File: design/rv_ex_alu.sv
`timescale 1ns/1ps

module rv_ex_alu
(
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_flush,
    input  logic                i_valid,
    output logic                o_ready,
    input  rv_ex_pkg::xlen_t    i_op1,
    input  rv_ex_pkg::xlen_t    i_op2,
    input  rv_ex_pkg::xlen_t    i_rs1_data,
    input  rv_ex_pkg::xlen_t    i_rs2_data,
    input  rv_ex_pkg::ex_ctrl_t i_ctrl,
    input  logic [4:0]          i_rd,
    input  rv_ex_pkg::pc_t      i_pc,
    input  rv_ex_pkg::pc_t      i_target,
    output logic                o_valid,
    input  logic                i_ready,
    output rv_ex_pkg::xlen_t    o_result,
    output logic [4:0]          o_rd,
    output logic                o_reg_write,
    output logic                o_redirect,
    output rv_ex_pkg::pc_t      o_target
);

    import rv_ex_pkg::*;

    localparam int SHAMT_BITS = $clog2($bits(xlen_t));

    logic [SHAMT_BITS-1:0] shamt;
    xlen_t alu_out;
    xlen_t result;
    pc_t   link_pc;
    logic  cond;
    logic  redirect;

    assign shamt = i_op2[SHAMT_BITS-1:0];

    always_comb
    begin
        case (i_ctrl.alu_op)
            ALU_SUB:  alu_out = i_op1 - i_op2;
            ALU_SLL:  alu_out = i_op1 << shamt;
            ALU_SLT:  alu_out = xlen_t'($signed(i_op1) < $signed(i_op2));
            ALU_SLTU: alu_out = xlen_t'(i_op1 < i_op2);
            ALU_XOR:  alu_out = i_op1 ^ i_op2;
            ALU_SRL:  alu_out = i_op1 >> shamt;
            ALU_SRA:  alu_out = xlen_t'($signed(i_op1) >>> shamt);
            ALU_OR:   alu_out = i_op1 | i_op2;
            ALU_AND:  alu_out = i_op1 & i_op2;
            default:  alu_out = i_op1 + i_op2;
        endcase
    end

    // Branch compare works on the raw register data, not the operands
    always_comb
    begin
        case (i_ctrl.br_cond)
            BR_EQ:   cond = (i_rs1_data == i_rs2_data);
            BR_NE:   cond = (i_rs1_data != i_rs2_data);
            BR_LT:   cond = ($signed(i_rs1_data) < $signed(i_rs2_data));
            BR_GE:   cond = ($signed(i_rs1_data) >= $signed(i_rs2_data));
            BR_LTU:  cond = (i_rs1_data < i_rs2_data);
            default: cond = (i_rs1_data >= i_rs2_data);
        endcase
    end

    assign link_pc  = i_pc + pc_t'(4);
    assign result   = (i_ctrl.is_jal || i_ctrl.is_jalr) ? xlen_t'(link_pc) : alu_out;
    assign redirect = i_ctrl.is_jal || i_ctrl.is_jalr || (i_ctrl.is_branch && cond);

    assign o_ready = !o_valid || i_ready;

    always_ff @(posedge i_clk)
    begin
        if (i_rst || i_flush)
        begin
            o_valid     <= 1'b0;
            o_redirect  <= 1'b0;
            o_reg_write <= 1'b0;
        end
        else if (o_ready)
        begin
            o_valid     <= i_valid;
            o_redirect  <= i_valid && redirect;     // Never raised for a bubble
            o_reg_write <= i_valid && i_ctrl.reg_write;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_valid && o_ready)
        begin
            o_result <= result;
            o_rd     <= i_rd;
            o_target <= i_target;
        end
    end

endmodule

// File: design/rv_ex_top.sv
`timescale 1ns/1ps

module rv_ex_top
(
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_flush,
    input  logic             i_valid,
    output logic             o_ready,
    input  logic [31:0]      i_instr,
    input  rv_ex_pkg::pc_t   i_pc,
    input  rv_ex_pkg::xlen_t i_rs1_data,
    input  rv_ex_pkg::xlen_t i_rs2_data,
    output logic             o_valid,
    input  logic             i_ready,
    output rv_ex_pkg::xlen_t o_result,
    output logic [4:0]       o_rd,
    output logic             o_reg_write,
    output logic             o_redirect,
    output rv_ex_pkg::pc_t   o_target
);

    import rv_ex_pkg::*;

    // Decode outputs
    ex_ctrl_t   dec_ctrl;
    logic [4:0] dec_rd;
    xlen_t      dec_imm_i, dec_imm_b, dec_imm_j;

    // Stage 1 to stage 2
    logic       ex1_valid;
    logic       ex2_ready;
    xlen_t      ex1_op1, ex1_op2;
    xlen_t      ex1_rs1_data, ex1_rs2_data;
    ex_ctrl_t   ex1_ctrl;
    logic [4:0] ex1_rd;
    pc_t        ex1_pc, ex1_target;

    rv_decode u_decode
    (
        .i_instr (i_instr),
        .o_ctrl  (dec_ctrl),
        .o_rd    (dec_rd),
        .o_imm_i (dec_imm_i),
        .o_imm_b (dec_imm_b),
        .o_imm_j (dec_imm_j)
    );

    rv_ex_operands u_ex1
    (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_flush    (i_flush),
        .i_valid    (i_valid),
        .o_ready    (o_ready),
        .i_ctrl     (dec_ctrl),
        .i_rd       (dec_rd),
        .i_imm_i    (dec_imm_i),
        .i_imm_b    (dec_imm_b),
        .i_imm_j    (dec_imm_j),
        .i_pc       (i_pc),
        .i_rs1_data (i_rs1_data),
        .i_rs2_data (i_rs2_data),
        .o_valid    (ex1_valid),
        .i_ready    (ex2_ready),
        .o_op1      (ex1_op1),
        .o_op2      (ex1_op2),
        .o_rs1_data (ex1_rs1_data),
        .o_rs2_data (ex1_rs2_data),
        .o_ctrl     (ex1_ctrl),
        .o_rd       (ex1_rd),
        .o_pc       (ex1_pc),
        .o_target   (ex1_target)
    );

    rv_ex_alu u_ex2
    (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_flush     (i_flush),
        .i_valid     (ex1_valid),
        .o_ready     (ex2_ready),
        .i_op1       (ex1_op1),
        .i_op2       (ex1_op2),
        .i_rs1_data  (ex1_rs1_data),
        .i_rs2_data  (ex1_rs2_data),
        .i_ctrl      (ex1_ctrl),
        .i_rd        (ex1_rd),
        .i_pc        (ex1_pc),
        .i_target    (ex1_target),
        .o_valid     (o_valid),
        .i_ready     (i_ready),
        .o_result    (o_result),
        .o_rd        (o_rd),
        .o_reg_write (o_reg_write),
        .o_redirect  (o_redirect),
        .o_target    (o_target)
    );

endmodule

// File: bench/rv_ex_sva.sv
`timescale 1ns/1ps

module rv_ex_sva
(
    input logic             i_clk,
    input logic             i_rst,
    input logic             i_flush,
    input logic             i_valid,
    input logic             o_ready,
    input logic [31:0]      i_instr,
    input logic             o_valid,
    input logic             i_ready,
    input rv_ex_pkg::xlen_t o_result,
    input logic [4:0]       o_rd,
    input logic             o_reg_write,
    input logic             o_redirect,
    input rv_ex_pkg::pc_t   o_target
);

    int fail_count = 0;

    // Both stages are empty one edge after reset or flush
    a_clear: assert property (@(posedge i_clk)
        (i_rst || i_flush) |=> !o_valid && !o_redirect && o_ready)
    else
    begin
        fail_count++;
        $error("Pipeline not empty after reset or flush");
    end

    a_stall_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        o_valid && !i_ready && !i_flush |=> o_valid && $stable(o_result) && $stable(o_rd)
            && $stable(o_reg_write) && $stable(o_redirect) && $stable(o_target))
    else
    begin
        fail_count++;
        $error("Output changed while stalled");
    end

    a_redirect_valid: assert property (@(posedge i_clk) disable iff (i_rst)
        o_redirect |-> o_valid)
    else
    begin
        fail_count++;
        $error("Redirect raised without a valid output");
    end

    // Upstream must hold its item until it is taken
    a_input_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        i_valid && !o_ready && !i_flush |=> i_valid && $stable(i_instr))
    else
    begin
        fail_count++;
        $error("Input item dropped before acceptance");
    end

endmodule

// File: bench/rv_ex_tb.sv
`timescale 1ns/1ps
`include "rv_ex_config.svh"

module rv_ex_tb;

    import rv_ex_pkg::*;

    logic        i_clk = 1'b0;
    logic        i_rst, i_flush, i_valid;
    logic        i_ready = 1'b1;
    logic [31:0] i_instr;
    pc_t         i_pc;
    xlen_t       i_rs1_data, i_rs2_data;
    logic        o_ready, o_valid, o_reg_write, o_redirect;
    xlen_t       o_result;
    logic [4:0]  o_rd;
    pc_t         o_target;

    logic [31:0] t_instr [`TB_LEN];
    pc_t         t_pc    [`TB_LEN];
    xlen_t       t_rs1   [`TB_LEN];
    xlen_t       t_rs2   [`TB_LEN];
    xlen_t       t_res   [`TB_LEN];
    logic [4:0]  t_rd    [`TB_LEN];
    logic        t_we    [`TB_LEN];
    logic        t_redir [`TB_LEN];
    pc_t         t_tgt   [`TB_LEN];
    int          n_items = 0;

    int          exp_q[$];    // Table index of each item in flight
    int          acc_q[$];    // Edge at which that item was accepted
    int          cyc = 0;
    int          errors = 0;
    logic        lat_mode = 1'b0;
    logic        rand_mode = 1'b0;
    logic        hold_ready = 1'b1;
    integer      seed = 32'hcf27_186b;

    rv_ex_top UUT (.*);

    bind rv_ex_top rv_ex_sva u_sva (.*);

    always #10 i_clk = ~i_clk;

    always @(posedge i_clk)
    begin
        cyc <= cyc + 1;
        if (rand_mode)
            i_ready <= ($random(seed) % 4) != 0;    // Ready about three cycles in four
        else
            i_ready <= hold_ready;
    end

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, 5'd2, 5'd1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {imm, 5'd1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] branch_word(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jal_word(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic add_entry(input logic [31:0] instr, input pc_t pc, input xlen_t rs1,
                             input xlen_t rs2, input xlen_t res, input logic [4:0] rd,
                             input logic we, input logic redir, input pc_t tgt);
        t_instr[n_items] = instr;
        t_pc[n_items]    = pc;
        t_rs1[n_items]   = rs1;
        t_rs2[n_items]   = rs2;
        t_res[n_items]   = res;
        t_rd[n_items]    = rd;
        t_we[n_items]    = we;
        t_redir[n_items] = redir;
        t_tgt[n_items]   = tgt;
        n_items++;
    endtask

    //############################################################
    // Stimulus table of word, pc, rs1, rs2, result, rd, we, redirect and target
    //############################################################
    task automatic load_table;
        add_entry(r_word('h00, 3'b000, 3), 'h100, 5, 7, 12, 3, 1, 0, 0);
        add_entry(r_word('h20, 3'b000, 4), 'h104, 5, 7, 'hfffffffe, 4, 1, 0, 0);
        add_entry(r_word('h00, 3'b001, 5), 'h108, 1, 'h24, 'h10, 5, 1, 0, 0);
        add_entry(r_word('h00, 3'b010, 6), 'h10c, 'hffffffff, 1, 1, 6, 1, 0, 0);
        add_entry(r_word('h00, 3'b011, 7), 'h110, 'hffffffff, 1, 0, 7, 1, 0, 0);
        add_entry(r_word('h00, 3'b100, 8), 'h114, 'hf0f0f0f0, 'h0ff00ff0, 'hff00ff00, 8, 1, 0, 0);
        add_entry(r_word('h00, 3'b101, 9), 'h118, 'h80000000, 4, 'h08000000, 9, 1, 0, 0);
        add_entry(r_word('h20, 3'b101, 10), 'h11c, 'h80000000, 4, 'hf8000000, 10, 1, 0, 0);
        add_entry(r_word('h00, 3'b110, 11), 'h120, 'hf0, 'h0f, 'hff, 11, 1, 0, 0);
        add_entry(r_word('h00, 3'b111, 12), 'h124, 'hf0f0, 'hff00, 'hf000, 12, 1, 0, 0);
        // Immediate forms ignore rs2 data
        add_entry(i_word('hffd, 3'b000, 13, OPC_OP_IMM), 'h128, 10, 0, 7, 13, 1, 0, 0);
        add_entry(i_word('hfff, 3'b100, 14, OPC_OP_IMM), 'h12c, 'hff, 0, 'hffffff00, 14, 1, 0, 0);
        add_entry(i_word('h408, 3'b101, 15, OPC_OP_IMM), 'h130, 'h80000000, 0, 'hff800000,
                  15, 1, 0, 0);
        add_entry(i_word('h005, 3'b010, 16, OPC_OP_IMM), 'h134, 'hfffffff0, 0, 1, 16, 1, 0, 0);
        add_entry(i_word('hfff, 3'b011, 17, OPC_OP_IMM), 'h138, 5, 0, 1, 17, 1, 0, 0);
        add_entry(branch_word('h010, 3'b000), 'h200, 5, 5, 0, 0, 0, 1, 'h210);
        add_entry(branch_word('h010, 3'b000), 'h204, 5, 6, 0, 0, 0, 0, 'h214);
        add_entry(branch_word('h1ff8, 3'b001), 'h300, 5, 6, 0, 0, 0, 1, 'h2f8);
        add_entry(branch_word('h1ff8, 3'b001), 'h304, 5, 5, 0, 0, 0, 0, 'h2fc);
        add_entry(branch_word('h040, 3'b100), 'h208, 'hffffffff, 1, 0, 0, 0, 1, 'h248);
        add_entry(branch_word('h040, 3'b100), 'h20c, 1, 'hffffffff, 0, 0, 0, 0, 'h24c);
        add_entry(branch_word('h800, 3'b101), 'h210, 1, 'hffffffff, 0, 0, 0, 1, 'ha10);
        add_entry(branch_word('h800, 3'b101), 'h214, 'hffffffff, 1, 0, 0, 0, 0, 'ha14);
        add_entry(branch_word('h1000, 3'b110), 'h2000, 1, 'hffffffff, 0, 0, 0, 1, 'h1000);
        add_entry(branch_word('h1000, 3'b110), 'h2004, 'hffffffff, 1, 0, 0, 0, 0, 'h1004);
        add_entry(branch_word('h002, 3'b111), 'h218, 'hffffffff, 1, 0, 0, 0, 1, 'h21a);
        add_entry(branch_word('h002, 3'b111), 'h21c, 1, 'hffffffff, 0, 0, 0, 0, 'h21e);
        add_entry(jal_word('h100, 1), 'h400, 0, 0, 'h404, 1, 1, 1, 'h500);
        add_entry(jal_word('h1fffe0, 1), 'h400, 0, 0, 'h404, 1, 1, 1, 'h3e0);
        add_entry(i_word('h010, 3'b000, 2, OPC_JALR), 'h500, 'h1001, 0, 'h504, 2, 1, 1, 'h1010);
        add_entry(i_word('hfff, 3'b000, 2, OPC_JALR), 'h600, 'h2000, 0, 'h604, 2, 1, 1, 'h1ffe);
    endtask

    task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp)
        begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        if (got !== exp)
        begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_item(input int k, input int acc);
        // The output transfer edge is the one after this sample
        if (lat_mode && cyc + 1 != acc + 2)
        begin
            $display("Item %0d left %0d edges after acceptance instead of 2", k,
                     cyc + 1 - acc);
            errors++;
        end
        check_bit($sformatf("o_reg_write (item %0d)", k), o_reg_write, t_we[k]);
        check_bit($sformatf("o_redirect (item %0d)", k), o_redirect, t_redir[k]);
        if (t_we[k])
        begin
            check_word($sformatf("o_result (item %0d)", k), o_result, t_res[k]);
            check_word($sformatf("o_rd (item %0d)", k), xlen_t'(o_rd), xlen_t'(t_rd[k]));
        end
        if (!t_we[k] || t_redir[k])
            check_pc($sformatf("o_target (item %0d)", k), o_target, t_tgt[k]);
    endtask

    // Outputs are sampled at the falling edge and transfer on the next rising one
    always @(negedge i_clk)
    begin
        if (!i_rst && o_valid === 1'b1 && i_ready)
        begin
            if (exp_q.size() == 0)
            begin
                $display("Output transfer at edge %0d with no input in flight", cyc);
                errors++;
            end
            else
                check_item(exp_q.pop_front(), acc_q.pop_front());
        end
    end

    task automatic send_item(input int k);
        @(posedge i_clk);
        i_valid    <= 1'b1;
        i_instr    <= t_instr[k];
        i_pc       <= t_pc[k];
        i_rs1_data <= t_rs1[k];
        i_rs2_data <= t_rs2[k];
        @(negedge i_clk);
        while (!o_ready)
        begin
            if (lat_mode)
            begin
                $display("Input %0d stalled at edge %0d with i_ready held high", k, cyc);
                errors++;
            end
            @(negedge i_clk);
        end
        exp_q.push_back(k);
        acc_q.push_back(cyc + 1);
    endtask

    task automatic run_table;
        for (int k = 0; k < n_items; k++)
            send_item(k);
        @(posedge i_clk);
        i_valid <= 1'b0;
        while (exp_q.size() != 0)
            @(posedge i_clk);
    endtask

    initial
    begin
        i_rst      = 1'b1;
        i_flush    = 1'b0;
        i_valid    = 1'b0;
        i_instr    = '0;
        i_pc       = '0;
        i_rs1_data = '0;
        i_rs2_data = '0;
        load_table();
        repeat (4) @(posedge i_clk);
        i_rst <= 1'b0;

        lat_mode = 1'b1;
        run_table();
        lat_mode = 1'b0;

        //############################################################
        // Fill both stages while stalled and then flush them
        //############################################################
        @(posedge i_clk);
        hold_ready <= 1'b0;
        @(posedge i_clk);
        send_item(0);
        send_item(1);
        @(posedge i_clk);
        i_valid <= 1'b0;
        i_flush <= 1'b1;
        @(posedge i_clk);
        i_flush    <= 1'b0;
        hold_ready <= 1'b1;
        exp_q.delete();
        acc_q.delete();
        repeat (6) @(posedge i_clk);

        rand_mode <= 1'b1;
        run_table();
        rand_mode <= 1'b0;
        repeat (2) @(posedge i_clk);

        $display("Errors: %0d value checks, %0d assertions", errors, UUT.u_sva.fail_count);
        if (errors == 0 && UUT.u_sva.fail_count == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    initial
    begin
        #1;    // Table is loaded at time zero
        repeat (n_items * 40 + 200) @(posedge i_clk);
        $display("Watchdog expired at edge %0d, the pipeline stopped moving", cyc);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: sources.f
+incdir+include
design/rv_ex_pkg.sv
design/rv_decode.sv
design/rv_ex_operands.sv
design/rv_ex_alu.sv
design/rv_ex_top.sv
bench/rv_ex_sva.sv
bench/rv_ex_tb.sv
